// ==== common/board_pkg.sv ====
`default_nettype none

package board_pkg;

  localparam int NUM_DIGITS = 8;
  localparam int DISP_WIDTH = 64;
  localparam int LED_FRAME_NUM = 19;

  // eight active-low segment bytes per frame, digit 0 in the low byte.
  localparam logic [DISP_WIDTH-1:0] LED_FRAME_TABLE [0:LED_FRAME_NUM-1] = '{
    64'hFFFFFFFEFEFEFEFE,
    64'hFFFEFEFEFEFEFFFF,
    64'hDEFEFEFEFFFFFFFF,
    64'hCEFEFEFFFFFFFFFF,
    64'hC2FFFFFFFFFFFFFF,
    64'hC1FEFFFFFFFFFFFF,
    64'hF1FDFFFFFFFFFFFF,
    64'hFDF8F7FFFFFFFFFF,
    64'hFFF8F3FFFFFFFFFF,
    64'hFFFBF1FEFFFFFFFF,
    64'hFFFFF9F8FFFFFFFF,
    64'hFFFFFCF8F7FFFFFF,
    64'hFFFFFFF9F1FFFFFF,
    64'hFFFFFFFFF1FCFFFF,
    64'hFFFFFFFFF9F8FFFF,
    64'hFFFFFFFFFFF8F3FF,
    64'hFFFFFFFFFFFBF1FE,
    64'hFFFFFFFFFFFFF9BC,
    64'hFFFFFFFFFFFFBDBC
  };

  localparam logic [DISP_WIDTH-1:0] LED_BLANK = '1; // all segments off.

  // one-hot codes from switches 14:11.
  typedef enum logic [3:0] {
    SRC_INSTR = 4'b1000,
    SRC_REG   = 4'b0100,
    SRC_ALU   = 4'b0010,
    SRC_DMEM  = 4'b0001
  } disp_src_e;

  // segments a..g on bits 0..6, active low, dp on bit 7 held off.
  localparam logic [7:0] HEX_FONT [0:15] = '{
    8'hC0, 8'hF9, 8'hA4, 8'hB0,
    8'h99, 8'h92, 8'h82, 8'hF8,
    8'h80, 8'h90, 8'h88, 8'h83,
    8'hC6, 8'hA1, 8'h86, 8'h8E
  };

endpackage

`default_nettype wire

// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  localparam int XLEN = 32;
  localparam int IMEM_DEPTH = 12;
  localparam int IMEM_AW = 6;

  localparam logic [XLEN-1:0] IMEM_PROGRAM [0:IMEM_DEPTH-1] = '{
    32'h00500093, // addi x1, x0, 5.
    32'h00300113, // addi x2, x0, 3.
    32'h002081B3, // add  x3, x1, x2.
    32'h40208233, // sub  x4, x1, x2.
    32'h0020F2B3, // and  x5, x1, x2.
    32'h0020E333, // or   x6, x1, x2.
    32'h00302023, // sw   x3, 0(x0).
    32'h00002383, // lw   x7, 0(x0).
    32'h00338463, // beq  x7, x3, +8.
    32'h00209413, // slli x8, x1, 2.
    32'h123454B7, // lui  x9, 0x12345.
    32'h0000006F  // jal  x0, 0.
  };

endpackage

`default_nettype wire

// ==== source/step_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_timer #(
  parameter int FAST_BIT = 25,
  parameter int SLOW_BIT = 27
) (
  input  wire logic Clk_CPU,
  input  wire logic rstn,
  input  wire logic slow_sel_i,
  output logic      step_o
);

  logic [31:0] div_cnt;
  logic [31:0] div_nxt;
  logic        tap_cur;
  logic        tap_nxt;

  assign div_nxt = div_cnt + 32'd1;

  // look one count ahead so the pulse lines up with the tap rising.
  assign tap_cur = slow_sel_i ? div_cnt[SLOW_BIT] : div_cnt[FAST_BIT];
  assign tap_nxt = slow_sel_i ? div_nxt[SLOW_BIT] : div_nxt[FAST_BIT];

  always_ff @(posedge Clk_CPU or negedge rstn) begin
    if (!rstn) begin
      div_cnt <= '0;
      step_o  <= 1'b0;
    end else begin
      div_cnt <= div_nxt;
      step_o  <= tap_nxt & ~tap_cur;
    end
  end

endmodule

`default_nettype wire

// ==== source/led_pattern_player.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_pattern_player
  import board_pkg::*;
(
  input  wire logic                  Clk_CPU,
  input  wire logic                  rstn,
  input  wire logic                  step_i,
  input  wire logic                  enable_i,
  output logic      [DISP_WIDTH-1:0] frame_o
);

  localparam int IDX_W = $clog2(LED_FRAME_NUM);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(LED_FRAME_NUM - 1);

  logic [IDX_W-1:0] frame_idx;
  logic             advance;

  assign advance = step_i & enable_i;

  always_ff @(posedge Clk_CPU or negedge rstn) begin
    if (!rstn) begin
      frame_idx <= '0;
    end else if (advance) begin
      if (frame_idx == LAST_IDX) begin
        frame_idx <= '0; // loop the animation.
      end else begin
        frame_idx <= frame_idx + 1'b1;
      end
    end
  end

  // frame shows up one cycle after the step.
  always_ff @(posedge Clk_CPU or negedge rstn) begin
    if (!rstn) begin
      frame_o <= LED_BLANK;
    end else if (advance) begin
      frame_o <= LED_FRAME_TABLE[frame_idx];
    end
  end

endmodule

`default_nettype wire

// ==== source/instr_rom_stepper.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_rom_stepper
  import cpu_pkg::*;
(
  input  wire logic            Clk_CPU,
  input  wire logic            rstn,
  input  wire logic            step_i,
  input  wire logic            enable_i,
  output logic      [XLEN-1:0] instr_o
);

  localparam int ROM_WORDS = 2 ** IMEM_AW;
  localparam logic [IMEM_AW-1:0] LAST_ADDR = IMEM_AW'(IMEM_DEPTH - 1);

  logic [IMEM_AW-1:0] rom_addr;
  logic [XLEN-1:0]    rom_mem [ROM_WORDS];

  // program at the bottom, zeros above it.
  for (genvar g = 0; g < ROM_WORDS; g++) begin : g_rom
    if (g < IMEM_DEPTH) begin : g_word
      assign rom_mem[g] = IMEM_PROGRAM[g];
    end else begin : g_pad
      assign rom_mem[g] = '0;
    end
  end

  always_ff @(posedge Clk_CPU or negedge rstn) begin
    if (!rstn) begin
      rom_addr <= '0;
    end else if (step_i && enable_i) begin
      if (rom_addr == LAST_ADDR) begin
        rom_addr <= '0;
      end else begin
        rom_addr <= rom_addr + 1'b1;
      end
    end
  end

  assign instr_o = rom_mem[rom_addr]; // async read.

endmodule

`default_nettype wire

// ==== source/display_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module display_select
  import board_pkg::*, cpu_pkg::*;
(
  input  wire logic                  graphic_i,
  input  wire logic [3:0]            src_sel_i,
  input  wire logic [DISP_WIDTH-1:0] frame_i,
  input  wire logic [XLEN-1:0]       instr_i,
  input  wire logic [XLEN-1:0]       reg_data_i,
  input  wire logic [XLEN-1:0]       alu_data_i,
  input  wire logic [XLEN-1:0]       dmem_data_i,
  output logic      [DISP_WIDTH-1:0] disp_data_o,
  output logic                       disp_mode_o
);

  disp_src_e       src;
  logic [XLEN-1:0] dbg_word;

  assign src = disp_src_e'(src_sel_i);

  always_comb begin
    case (src)
      SRC_REG:  dbg_word = reg_data_i;
      SRC_ALU:  dbg_word = alu_data_i;
      SRC_DMEM: dbg_word = dmem_data_i;
      default:  dbg_word = instr_i; // SRC_INSTR and illegal codes.
    endcase
  end

  always_comb begin
    if (graphic_i) begin
      disp_data_o = frame_i;
    end else begin
      disp_data_o = DISP_WIDTH'(dbg_word);
    end
  end

  assign disp_mode_o = graphic_i;

endmodule

`default_nettype wire

// ==== seg7/seg7x16.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg7x16
  import board_pkg::*;
#(
  parameter int SCAN_BIT = 15
) (
  input  wire logic                  Clk_CPU,
  input  wire logic                  rstn,
  input  wire logic [DISP_WIDTH-1:0] disp_data_i,
  input  wire logic                  disp_mode_i,
  output logic      [7:0]            disp_seg_o,
  output logic      [NUM_DIGITS-1:0] disp_an_o
);

  localparam int DIG_W = $clog2(NUM_DIGITS);
  localparam int CNT_W = SCAN_BIT + DIG_W;

  logic [CNT_W-1:0] scan_cnt;
  logic [CNT_W-1:0] scan_nxt;
  logic [DIG_W-1:0] digit_cur;
  logic [DIG_W-1:0] digit_nxt;
  logic             slot_start;
  logic [3:0]       digit_nibble;
  logic [7:0]       digit_byte;
  logic [7:0]       seg_nxt;

  assign scan_nxt  = scan_cnt + 1'b1;
  assign digit_cur = scan_cnt[CNT_W-1:SCAN_BIT];
  assign digit_nxt = scan_nxt[CNT_W-1:SCAN_BIT];

  // digit field about to change, load the next digit's outputs.
  assign slot_start = (digit_nxt != digit_cur);

  assign digit_nibble = disp_data_i[digit_nxt*4 +: 4];
  assign digit_byte   = disp_data_i[digit_nxt*8 +: 8];

  always_comb begin
    if (disp_mode_i) begin
      seg_nxt = digit_byte; // raw segments.
    end else begin
      seg_nxt = HEX_FONT[digit_nibble];
    end
  end

  always_ff @(posedge Clk_CPU or negedge rstn) begin
    if (!rstn) begin
      scan_cnt <= '0;
    end else begin
      scan_cnt <= scan_nxt;
    end
  end

  // blank until the first slot boundary.
  always_ff @(posedge Clk_CPU or negedge rstn) begin
    if (!rstn) begin
      disp_seg_o <= 8'hFF;
      disp_an_o  <= '1;
    end else if (slot_start) begin
      disp_seg_o <= seg_nxt;
      disp_an_o  <= ~(NUM_DIGITS'(1) << digit_nxt);
    end
  end

endmodule

`default_nettype wire

// ==== source/debug_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_display_top
  import board_pkg::*, cpu_pkg::*;
#(
  parameter int FAST_BIT = 25,
  parameter int SLOW_BIT = 27,
  parameter int SCAN_BIT = 15
) (
  input  wire logic                  Clk_CPU,
  input  wire logic                  rstn,
  input  wire logic [15:0]           sw_i,
  input  wire logic [XLEN-1:0]       reg_data_i,
  input  wire logic [XLEN-1:0]       alu_data_i,
  input  wire logic [XLEN-1:0]       dmem_data_i,
  output logic      [7:0]            disp_seg_o,
  output logic      [NUM_DIGITS-1:0] disp_an_o
);

  logic                  step;
  logic [DISP_WIDTH-1:0] led_frame;
  logic [XLEN-1:0]       instr;
  logic [DISP_WIDTH-1:0] disp_data;
  logic                  disp_mode;

  step_timer #(
    .FAST_BIT(FAST_BIT),
    .SLOW_BIT(SLOW_BIT)
  ) u_step_timer (
    .Clk_CPU   (Clk_CPU),
    .rstn      (rstn),
    .slow_sel_i(sw_i[15]),
    .step_o    (step)
  );

  led_pattern_player u_led_pattern_player (
    .Clk_CPU (Clk_CPU),
    .rstn    (rstn),
    .step_i  (step),
    .enable_i(sw_i[0]),
    .frame_o (led_frame)
  );

  instr_rom_stepper u_instr_rom_stepper (
    .Clk_CPU (Clk_CPU),
    .rstn    (rstn),
    .step_i  (step),
    .enable_i(sw_i[1]),
    .instr_o (instr)
  );

  display_select u_display_select (
    .graphic_i  (sw_i[0]),
    .src_sel_i  (sw_i[14:11]),
    .frame_i    (led_frame),
    .instr_i    (instr),
    .reg_data_i (reg_data_i),
    .alu_data_i (alu_data_i),
    .dmem_data_i(dmem_data_i),
    .disp_data_o(disp_data),
    .disp_mode_o(disp_mode)
  );

  seg7x16 #(
    .SCAN_BIT(SCAN_BIT)
  ) u_seg7x16 (
    .Clk_CPU    (Clk_CPU),
    .rstn       (rstn),
    .disp_data_i(disp_data),
    .disp_mode_i(disp_mode),
    .disp_seg_o (disp_seg_o),
    .disp_an_o  (disp_an_o)
  );

endmodule

`default_nettype wire

// ==== verification/tb_debug_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_debug_display
  import board_pkg::*, cpu_pkg::*;
();

  localparam int FAST_BIT = 6;
  localparam int SLOW_BIT = 8;
  localparam int SCAN_BIT = 1;
  localparam int NUM_VECS = 9;
  localparam int SCAN_CYCLES = NUM_DIGITS * (2 ** SCAN_BIT);
  localparam int FAST_STEP = 2 ** (FAST_BIT + 1);
  localparam int SLOW_STEP = 2 ** (SLOW_BIT + 1);
  localparam int CAPTURE_GAP = 32; // keeps captures closer than one step.
  localparam int TIMEOUT_CYCLES = NUM_VECS * 2 * SCAN_CYCLES + 60 * SLOW_STEP + 2000;

  logic            Clk_CPU;
  logic            rstn;
  logic [15:0]     sw;
  logic [XLEN-1:0] reg_data;
  logic [XLEN-1:0] alu_data;
  logic [XLEN-1:0] dmem_data;
  logic [7:0]      disp_seg;
  logic [7:0]      disp_an;
  logic [175:0]    vec_mem [NUM_VECS];
  int              errors = 0;
  int              checks = 0;
  int              cycle_cnt;

  debug_display_top #(
    .FAST_BIT(FAST_BIT),
    .SLOW_BIT(SLOW_BIT),
    .SCAN_BIT(SCAN_BIT)
  ) u_debug_display_top (
    .Clk_CPU    (Clk_CPU),
    .rstn       (rstn),
    .sw_i       (sw),
    .reg_data_i (reg_data),
    .alu_data_i (alu_data),
    .dmem_data_i(dmem_data),
    .disp_seg_o (disp_seg),
    .disp_an_o  (disp_an)
  );

  always #4 Clk_CPU = ~Clk_CPU; // 8 ns period.

  task automatic check_value(input string sig, input logic [63:0] expected,
                             input logic [63:0] observed);
    checks++;
    assert (observed === expected) else begin
      errors++;
      $display("** Error @ %0t: %s expected %0h observed %0h", $time, sig, expected, observed);
    end
  endtask

  task automatic check_condition(input bit ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Error @ %0t: %s", $time, what);
    end
  endtask

  task automatic set_inputs(input logic [15:0] sw_val, input logic [XLEN-1:0] reg_val,
                            input logic [XLEN-1:0] alu_val, input logic [XLEN-1:0] dmem_val);
    @(posedge Clk_CPU);
    sw        <= sw_val;
    reg_data  <= reg_val;
    alu_data  <= alu_val;
    dmem_data <= dmem_val;
  endtask

  // one full scan starting at a digit 0 slot loaded after the call.
  task automatic capture_scan(output logic [63:0] frame);
    logic [7:0] prev_an;
    int         k;
    @(negedge Clk_CPU);
    prev_an = disp_an;
    @(negedge Clk_CPU);
    while (!(disp_an == 8'hFE && prev_an != 8'hFE)) begin
      prev_an = disp_an;
      @(negedge Clk_CPU);
    end
    frame[7:0] = disp_seg;
    for (k = 1; k < NUM_DIGITS; k++) begin
      while (disp_an != ~(8'h01 << k)) begin
        @(negedge Clk_CPU);
      end
      frame[k*8 +: 8] = disp_seg;
    end
  endtask

  task automatic capture_stable(output logic [63:0] frame);
    logic [63:0] last;
    int          tries;
    capture_scan(last);
    capture_scan(frame);
    tries = 0;
    while (frame != last && tries < 4) begin // a step landed inside the scan.
      last = frame;
      capture_scan(frame);
      tries++;
    end
    check_condition(frame == last, "display never held one value for two scans");
  endtask

  function automatic logic [63:0] text_frame(input logic [XLEN-1:0] word);
    logic [63:0] f;
    int          k;
    for (k = 0; k < NUM_DIGITS; k++) begin
      f[k*8 +: 8] = HEX_FONT[word[k*4 +: 4]];
    end
    return f;
  endfunction

  // -1 is the blank frame, -2 matches nothing.
  function automatic int seq_index(input bit graphic, input logic [63:0] frame);
    int idx;
    int i;
    idx = -2;
    if (graphic) begin
      if (frame == LED_BLANK) idx = -1;
      for (i = 0; i < LED_FRAME_NUM; i++) begin
        if (frame == LED_FRAME_TABLE[i]) idx = i;
      end
    end else begin
      for (i = 0; i < IMEM_DEPTH; i++) begin
        if (frame == text_frame(IMEM_PROGRAM[i])) idx = i;
      end
    end
    return idx;
  endfunction

  task automatic follow_sequence(input bit graphic, input int captures);
    logic [63:0] frame;
    bit          seen [LED_FRAME_NUM];
    bit          wrapped;
    int          len;
    int          prev;
    int          idx;
    int          seen_cnt;
    int          n;
    len = graphic ? LED_FRAME_NUM : IMEM_DEPTH;
    seen = '{default: 1'b0};
    wrapped = 1'b0;
    prev = -2;
    seen_cnt = 0;
    for (n = 0; n < captures; n++) begin
      repeat (CAPTURE_GAP) @(posedge Clk_CPU);
      capture_stable(frame);
      idx = seq_index(graphic, frame);
      if (n == 0) begin
        check_condition(graphic ? (idx == -1 || idx == 0) : (idx >= 0),
                        "first captured frame is not a valid start of the sequence");
      end else begin
        check_condition(idx >= -1 && (idx == prev || idx == (prev + 1) % len),
                        $sformatf("captured index %0d does not follow index %0d", idx, prev));
      end
      if (prev == len - 1 && idx == 0) wrapped = 1'b1;
      if (idx >= 0 && !seen[idx]) begin
        seen[idx] = 1'b1;
        seen_cnt++;
      end
      prev = idx;
    end
    check_condition(wrapped && seen_cnt == len, "sequence did not show every entry and the wrap");
  endtask

  // scans from the first scan of one word to the first scan of the next.
  task automatic measure_dwell(output int scans);
    logic [63:0] frame;
    int          start_idx;
    int          idx;
    capture_scan(frame);
    start_idx = seq_index(1'b0, frame);
    idx = start_idx;
    scans = 0;
    while ((idx < 0 || idx == start_idx) && scans < 100) begin
      capture_scan(frame);
      idx = seq_index(1'b0, frame);
      scans++;
    end
    start_idx = idx;
    scans = 0;
    while ((idx < 0 || idx == start_idx) && scans < 100) begin
      scans++;
      capture_scan(frame);
      idx = seq_index(1'b0, frame);
    end
    check_condition(scans < 100, "displayed word never changed while stepping");
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge Clk_CPU);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles with the test sequence unfinished", cycle_cnt);
    $display("checks %0d errors %0d", checks, errors);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    logic [175:0] vec;
    logic [63:0]  frame;
    logic [63:0]  held;
    int           fast_dwell;
    int           slow_dwell;
    int           v;
    int           k;
    Clk_CPU   = 1'b0;
    rstn      = 1'b0;
    sw        = '0;
    reg_data  = '0;
    alu_data  = '0;
    dmem_data = '0;
    $readmemh("verification/stim_input.hex", vec_mem);
    repeat (10) @(posedge Clk_CPU);
    rstn <= 1'b1;
    repeat (2 ** SCAN_BIT) begin // no digit lit for the whole first digit period.
      @(negedge Clk_CPU);
      check_value("disp_an_o after reset", 64'hFF, 64'(disp_an));
    end

    for (v = 0; v < NUM_VECS; v++) begin
      vec = vec_mem[v];
      check_condition(!$isunknown(vec), $sformatf("stimulus vector %0d was not read", v));
      set_inputs(vec[175:160], vec[159:128], vec[127:96], vec[95:64]);
      capture_scan(frame);
      for (k = 0; k < NUM_DIGITS; k++) begin
        check_value($sformatf("disp_seg_o digit %0d of vector %0d", k, v),
                    64'(vec[k*8 +: 8]), 64'(frame[k*8 +: 8]));
      end
    end

    set_inputs(16'h0001, reg_data, alu_data, dmem_data); // animation in graphic mode.
    follow_sequence(1'b1, 50);
    set_inputs(16'h4002, reg_data, alu_data, dmem_data); // instruction source, stepping on.
    follow_sequence(1'b0, 30);

    measure_dwell(fast_dwell);
    set_inputs(16'hC002, reg_data, alu_data, dmem_data);
    measure_dwell(slow_dwell); // this interval can be cut by the rate change.
    measure_dwell(slow_dwell);
    check_condition(fast_dwell >= FAST_STEP / SCAN_CYCLES - 1 &&
                    fast_dwell <= FAST_STEP / SCAN_CYCLES + 1,
                    $sformatf("fast rate held a word for %0d scans", fast_dwell));
    check_condition(slow_dwell >= 4 * fast_dwell - 1 && slow_dwell <= 4 * fast_dwell + 1,
                    $sformatf("slow dwell %0d scans is not four times fast dwell %0d scans",
                              slow_dwell, fast_dwell));

    set_inputs(16'h4000, reg_data, alu_data, dmem_data);
    repeat (SCAN_CYCLES) @(posedge Clk_CPU);
    capture_stable(held);
    check_condition(seq_index(1'b0, held) >= 0, "frozen display is not a program word");
    repeat (4 * FAST_STEP) @(posedge Clk_CPU);
    capture_stable(frame);
    check_value("disp_seg_o frame after disabling the stepper", held, frame);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
common/board_pkg.sv
common/cpu_pkg.sv
source/step_timer.sv
source/led_pattern_player.sv
source/instr_rom_stepper.sv
source/display_select.sv
seg7/seg7x16.sv
source/debug_display_top.sv
verification/tb_debug_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the debug display testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_debug_display -f flist.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vtb_debug_display)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

// ==== verification/stim_input.hex ====
// each line holds sw (4 hex digits) then the reg, alu and dmem words (8 hex digits each)
// and then the expected 64-bit segment frame with digit 7 first and digit 0 last.
// register, alu and data memory sources.
200012345678DEADBEEF0F1E2D3CF9A4B0999282F880
100012345678DEADBEEF0F1E2D3CA18688A18386868E
080012345678DEADBEEF0F1E2D3CC08EF986A4A1B0C6
20009ABCDEF000000000FFFFFFFF908883C6A1868EC0
10009ABCDEF000000000FFFFFFFFC0C0C0C0C0C0C0C0
08009ABCDEF000000000FFFFFFFF8E8E8E8E8E8E8E8E
// instruction source and the two illegal codes show word 0.
400012345678DEADBEEF0F1E2D3CC0C092C0C0C090B0
00009ABCDEF000000000FFFFFFFFC0C092C0C0C090B0
600012345678DEADBEEF0F1E2D3CC0C092C0C0C090B0
